/* rtl/lpgbt_uplink_defs.svh */
`ifndef LPGBT_UPLINK_DEFS_SVH
`define LPGBT_UPLINK_DEFS_SVH

// AXI4-Lite bus widths
`define LPGBT_AXI_DATA_WIDTH  32
`define LPGBT_AXI_ADDR_WIDTH  11

// One lpGBT uplink user frame
`define LPGBT_FRAME_WIDTH     234

// Word index taken from address bits 5..2
`define LPGBT_REG_INDEX_WIDTH 4

// Register map, word indices
`define LPGBT_REG_CONTROL     0
`define LPGBT_REG_STATUS      1
`define LPGBT_REG_FRAME_CNT   2
`define LPGBT_REG_FEC_CNT     3
`define LPGBT_REG_SNAP_BASE   4
`define LPGBT_REG_COUNT       12

// Control register bits
`define LPGBT_CTRL_RST_BIT    0
`define LPGBT_CTRL_POL_BIT    1
`define LPGBT_CTRL_ARM_BIT    2

// Status register bits
`define LPGBT_STAT_READY_BIT  0
`define LPGBT_STAT_VALID_BIT  1
`define LPGBT_STAT_ARMED_BIT  2

`endif

/* rtl/lpgbt_uplink_pkg.sv */
`include "lpgbt_uplink_defs.svh"

package lpgbt_uplink_pkg;

    // One register word on the AXI data bus
    typedef logic [`LPGBT_AXI_DATA_WIDTH-1:0] axi_data_t;

    // Byte address as seen on AWADDR / ARADDR
    typedef logic [`LPGBT_AXI_ADDR_WIDTH-1:0] axi_addr_t;

    // One enable per byte lane of the data bus
    typedef logic [`LPGBT_AXI_DATA_WIDTH/8-1:0] byte_strobe_t;

    // Word index, address bits 5..2
    typedef logic [`LPGBT_REG_INDEX_WIDTH-1:0] reg_index_t;

    // Decoded uplink user frame
    typedef logic [`LPGBT_FRAME_WIDTH-1:0] uplink_frame_t;

    // Saturating event counter value
    typedef logic [31:0] event_count_t;

    // Slave FSM, one transaction in flight
    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_DATA
    } axi_state_t;

endpackage

/* rtl/lpgbt_reg_if.sv */
`timescale 1ns/100ps

interface lpgbt_reg_if;

    // Write side, valid only while wr_strobe is nonzero
    lpgbt_uplink_pkg::reg_index_t   wr_index;
    lpgbt_uplink_pkg::axi_data_t    wr_data;
    lpgbt_uplink_pkg::byte_strobe_t wr_strobe;

    // Read side, rd_data follows rd_index combinationally
    lpgbt_uplink_pkg::reg_index_t   rd_index;
    logic                           rd_strobe;
    lpgbt_uplink_pkg::axi_data_t    rd_data;

    // Bus side, owned by the AXI slave FSM
    modport bus (
        output wr_index, wr_data, wr_strobe,
        output rd_index, rd_strobe,
        input  rd_data
    );

    // Register side, owned by the register bank
    modport regs (
        input  wr_index, wr_data, wr_strobe,
        input  rd_index,
        output rd_data
    );

endinterface

/* rtl/axi4lite_slave_fsm.sv */
`timescale 1ns/100ps
`include "lpgbt_uplink_defs.svh"

module axi4lite_slave_fsm (
    input  logic                           S_AXI_ACLK,
    input  logic                           S_AXI_ARESETN,
    // Write address and data channels
    input  lpgbt_uplink_pkg::axi_addr_t    S_AXI_AWADDR,
    input  logic                           S_AXI_AWVALID,
    output logic                           S_AXI_AWREADY,
    input  lpgbt_uplink_pkg::axi_data_t    S_AXI_WDATA,
    input  lpgbt_uplink_pkg::byte_strobe_t S_AXI_WSTRB,
    input  logic                           S_AXI_WVALID,
    output logic                           S_AXI_WREADY,
    // Write response channel
    output logic                           S_AXI_BVALID,
    output logic [1:0]                     S_AXI_BRESP,
    input  logic                           S_AXI_BREADY,
    // Read address channel
    input  lpgbt_uplink_pkg::axi_addr_t    S_AXI_ARADDR,
    input  logic                           S_AXI_ARVALID,
    output logic                           S_AXI_ARREADY,
    // Read data channel
    output logic                           S_AXI_RVALID,
    output lpgbt_uplink_pkg::axi_data_t    S_AXI_RDATA,
    output logic [1:0]                     S_AXI_RRESP,
    input  logic                           S_AXI_RREADY,
    // Register strobes towards the bank
    lpgbt_reg_if.bus                       reg_if
);

    lpgbt_uplink_pkg::axi_state_t state_q;
    lpgbt_uplink_pkg::axi_state_t state_d;
    lpgbt_uplink_pkg::axi_data_t  rdata_q;
    logic                         wr_accept;
    logic                         rd_accept;

    ////////////////////////////////////////////////////////////////////////////
    // Acceptance
    ////////////////////////////////////////////////////////////////////////////

    // Address and data taken together, only from IDLE
    assign wr_accept = (state_q == lpgbt_uplink_pkg::IDLE) && S_AXI_AWVALID && S_AXI_WVALID;
    // Write wins when both directions show up together
    assign rd_accept = (state_q == lpgbt_uplink_pkg::IDLE) && S_AXI_ARVALID && !wr_accept;

    assign S_AXI_AWREADY = wr_accept;
    assign S_AXI_WREADY  = wr_accept;
    assign S_AXI_ARREADY = rd_accept;

    // Word index from byte address, low two bits dropped
    assign reg_if.wr_index  = S_AXI_AWADDR[`LPGBT_REG_INDEX_WIDTH+1:2];
    assign reg_if.wr_data   = S_AXI_WDATA;
    // Lane enables only during the accepting cycle
    assign reg_if.wr_strobe = wr_accept ? S_AXI_WSTRB : '0;

    assign reg_if.rd_index  = S_AXI_ARADDR[`LPGBT_REG_INDEX_WIDTH+1:2];
    assign reg_if.rd_strobe = rd_accept;

    ////////////////////////////////////////////////////////////////////////////
    // State sequencing
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            lpgbt_uplink_pkg::IDLE: begin
                if (wr_accept) begin
                    state_d = lpgbt_uplink_pkg::WRITE_RESP;
                end else if (rd_accept) begin
                    state_d = lpgbt_uplink_pkg::READ_DATA;
                end
            end
            // Response held until the master takes it
            lpgbt_uplink_pkg::WRITE_RESP: begin
                if (S_AXI_BREADY) begin
                    state_d = lpgbt_uplink_pkg::IDLE;
                end
            end
            lpgbt_uplink_pkg::READ_DATA: begin
                if (S_AXI_RREADY) begin
                    state_d = lpgbt_uplink_pkg::IDLE;
                end
            end
            default: state_d = lpgbt_uplink_pkg::IDLE;
        endcase
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state_q <= lpgbt_uplink_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Read data captured on the strobe, stable while RVALID waits
    always_ff @(posedge S_AXI_ACLK) begin
        if (reg_if.rd_strobe) begin
            rdata_q <= reg_if.rd_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Responses
    ////////////////////////////////////////////////////////////////////////////

    assign S_AXI_BVALID = (state_q == lpgbt_uplink_pkg::WRITE_RESP);
    assign S_AXI_RVALID = (state_q == lpgbt_uplink_pkg::READ_DATA);
    assign S_AXI_RDATA  = rdata_q;

    // Always OKAY, unmapped reads just return zero
    assign S_AXI_BRESP  = 2'b00;
    assign S_AXI_RRESP  = 2'b00;

endmodule

/* rtl/uplink_event_counters.sv */
`timescale 1ns/100ps

module uplink_event_counters (
    input  logic                          S_AXI_ACLK,
    input  logic                          S_AXI_ARESETN,
    // Held high while the uplink is in reset
    input  logic                          clear_i,
    // One pulse per decoded frame
    input  logic                          uplink_strobe_i,
    input  logic                          uplink_ready_i,
    // Qualified by uplink_strobe_i
    input  logic                          uplink_fec_i,
    output lpgbt_uplink_pkg::event_count_t frame_count_o,
    output lpgbt_uplink_pkg::event_count_t fec_count_o
);

    // Increment that sticks at all ones
    function automatic lpgbt_uplink_pkg::event_count_t sat_inc(
        input lpgbt_uplink_pkg::event_count_t value,
        input logic                           enable
    );
        if (enable && (value != '1)) begin
            return value + 1'b1;
        end
        return value;
    endfunction

    // Frames only count once the link is locked
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN || clear_i) begin
            frame_count_o <= '0;
        end else begin
            frame_count_o <= sat_inc(frame_count_o, uplink_strobe_i && uplink_ready_i);
        end
    end

    // FEC flag, sampled with the frame strobe
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN || clear_i) begin
            fec_count_o <= '0;
        end else begin
            fec_count_o <= sat_inc(fec_count_o, uplink_strobe_i && uplink_fec_i);
        end
    end

endmodule

/* rtl/uplink_reg_bank.sv */
`timescale 1ns/100ps
`include "lpgbt_uplink_defs.svh"

module uplink_reg_bank (
    input  logic                           S_AXI_ACLK,
    input  logic                           S_AXI_ARESETN,
    // Register strobes from the slave FSM
    lpgbt_reg_if.regs                      reg_if,
    // Uplink side
    input  lpgbt_uplink_pkg::uplink_frame_t uplink_data_i,
    input  logic                           uplink_strobe_i,
    input  logic                           uplink_ready_i,
    // Counter values for readback
    input  lpgbt_uplink_pkg::event_count_t frame_count_i,
    input  lpgbt_uplink_pkg::event_count_t fec_count_i,
    // Control outputs
    output logic                           uplink_rst_o,
    output logic                           mgt_rxpolarity_o
);

    localparam int DW         = `LPGBT_AXI_DATA_WIDTH;
    localparam int SNAP_WORDS = (`LPGBT_FRAME_WIDTH + DW - 1) / DW;
    localparam int SNAP_BITS  = SNAP_WORDS * DW;

    lpgbt_uplink_pkg::axi_data_t     control_q;
    lpgbt_uplink_pkg::uplink_frame_t snapshot_q;
    logic [SNAP_BITS-1:0]            snap_padded;
    logic                            armed_q;
    logic                            valid_q;
    logic                            ctrl_sel;
    logic                            arm_req;

    ////////////////////////////////////////////////////////////////////////////
    // Control register
    ////////////////////////////////////////////////////////////////////////////

    assign ctrl_sel = (reg_if.wr_index == `LPGBT_REG_CONTROL);
    // Arm only counts when lane 0 is enabled
    assign arm_req  = ctrl_sel && reg_if.wr_strobe[0] && reg_if.wr_data[`LPGBT_CTRL_ARM_BIT];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            control_q <= '0;
        end else if (ctrl_sel) begin
            // Per-lane update
            for (int lane = 0; lane < DW / 8; lane++) begin
                if (reg_if.wr_strobe[lane]) begin
                    control_q[8*lane +: 8] <= reg_if.wr_data[8*lane +: 8];
                end
            end
            // Arm is a pulse, never held
            control_q[`LPGBT_CTRL_ARM_BIT] <= 1'b0;
        end
    end

    assign uplink_rst_o     = control_q[`LPGBT_CTRL_RST_BIT];
    assign mgt_rxpolarity_o = control_q[`LPGBT_CTRL_POL_BIT];

    ////////////////////////////////////////////////////////////////////////////
    // Frame capture
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            armed_q    <= 1'b0;
            valid_q    <= 1'b0;
            snapshot_q <= '0;
        end else begin
            // First strobe after the arm write
            if (armed_q && uplink_strobe_i) begin
                snapshot_q <= uplink_data_i;
                armed_q    <= 1'b0;
                valid_q    <= 1'b1;
            end
            // A fresh arm overrides a capture in the same cycle
            if (arm_req) begin
                armed_q <= 1'b1;
                valid_q <= 1'b0;
            end
        end
    end

    // Zero fill above the frame, upper bits of the last word
    assign snap_padded = SNAP_BITS'(snapshot_q);

    ////////////////////////////////////////////////////////////////////////////
    // Read multiplexer
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        reg_if.rd_data = '0;
        case (reg_if.rd_index)
            `LPGBT_REG_CONTROL: reg_if.rd_data = control_q;
            `LPGBT_REG_STATUS: begin
                reg_if.rd_data[`LPGBT_STAT_READY_BIT] = uplink_ready_i;
                reg_if.rd_data[`LPGBT_STAT_VALID_BIT] = valid_q;
                reg_if.rd_data[`LPGBT_STAT_ARMED_BIT] = armed_q;
            end
            `LPGBT_REG_FRAME_CNT: reg_if.rd_data = frame_count_i;
            `LPGBT_REG_FEC_CNT:   reg_if.rd_data = fec_count_i;
            default: begin
                // Snapshot words, least significant first; rest reads zero
                if (reg_if.rd_index >= `LPGBT_REG_SNAP_BASE &&
                    reg_if.rd_index < `LPGBT_REG_COUNT) begin
                    reg_if.rd_data =
                        snap_padded[DW*(reg_if.rd_index - `LPGBT_REG_SNAP_BASE) +: DW];
                end
            end
        endcase
    end

endmodule

/* rtl/lpgbt_uplink_ctrl_top.sv */
`timescale 1ns/100ps

module lpgbt_uplink_ctrl_top (
    input  logic                            S_AXI_ACLK,
    input  logic                            S_AXI_ARESETN,
    // AXI4-Lite slave
    input  lpgbt_uplink_pkg::axi_addr_t     S_AXI_AWADDR,
    input  logic [2:0]                      S_AXI_AWPROT,
    input  logic                            S_AXI_AWVALID,
    output logic                            S_AXI_AWREADY,
    input  lpgbt_uplink_pkg::axi_data_t     S_AXI_WDATA,
    input  lpgbt_uplink_pkg::byte_strobe_t  S_AXI_WSTRB,
    input  logic                            S_AXI_WVALID,
    output logic                            S_AXI_WREADY,
    output logic [1:0]                      S_AXI_BRESP,
    output logic                            S_AXI_BVALID,
    input  logic                            S_AXI_BREADY,
    input  lpgbt_uplink_pkg::axi_addr_t     S_AXI_ARADDR,
    input  logic [2:0]                      S_AXI_ARPROT,
    input  logic                            S_AXI_ARVALID,
    output logic                            S_AXI_ARREADY,
    output lpgbt_uplink_pkg::axi_data_t     S_AXI_RDATA,
    output logic [1:0]                      S_AXI_RRESP,
    output logic                            S_AXI_RVALID,
    input  logic                            S_AXI_RREADY,
    // Uplink receiver, synchronous to S_AXI_ACLK
    input  lpgbt_uplink_pkg::uplink_frame_t uplink_data_i,
    input  logic                            uplink_strobe_i,
    input  logic                            uplink_ready_i,
    input  logic                            uplink_fec_i,
    // Receiver control
    output logic                            uplink_rst_o,
    output logic                            mgt_rxpolarity_o
);

    // AWPROT / ARPROT accepted and left unconnected

    lpgbt_uplink_pkg::event_count_t frame_count;
    lpgbt_uplink_pkg::event_count_t fec_count;

    lpgbt_reg_if reg_if ();

    ////////////////////////////////////////////////////////////////////////////
    // Bus slave
    ////////////////////////////////////////////////////////////////////////////

    axi4lite_slave_fsm u_axi_slave (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .S_AXI_AWADDR  (S_AXI_AWADDR),
        .S_AXI_AWVALID (S_AXI_AWVALID),
        .S_AXI_AWREADY (S_AXI_AWREADY),
        .S_AXI_WDATA   (S_AXI_WDATA),
        .S_AXI_WSTRB   (S_AXI_WSTRB),
        .S_AXI_WVALID  (S_AXI_WVALID),
        .S_AXI_WREADY  (S_AXI_WREADY),
        .S_AXI_BVALID  (S_AXI_BVALID),
        .S_AXI_BRESP   (S_AXI_BRESP),
        .S_AXI_BREADY  (S_AXI_BREADY),
        .S_AXI_ARADDR  (S_AXI_ARADDR),
        .S_AXI_ARVALID (S_AXI_ARVALID),
        .S_AXI_ARREADY (S_AXI_ARREADY),
        .S_AXI_RVALID  (S_AXI_RVALID),
        .S_AXI_RDATA   (S_AXI_RDATA),
        .S_AXI_RRESP   (S_AXI_RRESP),
        .S_AXI_RREADY  (S_AXI_RREADY),
        .reg_if        (reg_if.bus)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Registers and counters
    ////////////////////////////////////////////////////////////////////////////

    uplink_reg_bank u_reg_bank (
        .S_AXI_ACLK       (S_AXI_ACLK),
        .S_AXI_ARESETN    (S_AXI_ARESETN),
        .reg_if           (reg_if.regs),
        .uplink_data_i    (uplink_data_i),
        .uplink_strobe_i  (uplink_strobe_i),
        .uplink_ready_i   (uplink_ready_i),
        .frame_count_i    (frame_count),
        .fec_count_i      (fec_count),
        .uplink_rst_o     (uplink_rst_o),
        .mgt_rxpolarity_o (mgt_rxpolarity_o)
    );

    // Uplink reset also clears the counters
    uplink_event_counters u_counters (
        .S_AXI_ACLK      (S_AXI_ACLK),
        .S_AXI_ARESETN   (S_AXI_ARESETN),
        .clear_i         (uplink_rst_o),
        .uplink_strobe_i (uplink_strobe_i),
        .uplink_ready_i  (uplink_ready_i),
        .uplink_fec_i    (uplink_fec_i),
        .frame_count_o   (frame_count),
        .fec_count_o     (fec_count)
    );

endmodule

/* testbench/tb_lpgbt_uplink_ctrl.sv */
`timescale 1ns/100ps
`include "lpgbt_uplink_defs.svh"

module tb_lpgbt_uplink_ctrl;

    // Handshake waits give up after this many cycles
    localparam int TIMEOUT_CYCLES = 50;
    localparam int SNAP_WORDS     = `LPGBT_REG_COUNT - `LPGBT_REG_SNAP_BASE;
    // Frame bits held in the last snapshot word
    localparam int LAST_WORD_BITS = `LPGBT_FRAME_WIDTH - (SNAP_WORDS - 1) * 32;

    logic                            S_AXI_ACLK = 1'b0;
    logic                            S_AXI_ARESETN;
    lpgbt_uplink_pkg::axi_addr_t     S_AXI_AWADDR;
    logic [2:0]                      S_AXI_AWPROT;
    logic                            S_AXI_AWVALID;
    logic                            S_AXI_AWREADY;
    lpgbt_uplink_pkg::axi_data_t     S_AXI_WDATA;
    lpgbt_uplink_pkg::byte_strobe_t  S_AXI_WSTRB;
    logic                            S_AXI_WVALID;
    logic                            S_AXI_WREADY;
    logic [1:0]                      S_AXI_BRESP;
    logic                            S_AXI_BVALID;
    logic                            S_AXI_BREADY;
    lpgbt_uplink_pkg::axi_addr_t     S_AXI_ARADDR;
    logic [2:0]                      S_AXI_ARPROT;
    logic                            S_AXI_ARVALID;
    logic                            S_AXI_ARREADY;
    lpgbt_uplink_pkg::axi_data_t     S_AXI_RDATA;
    logic [1:0]                      S_AXI_RRESP;
    logic                            S_AXI_RVALID;
    logic                            S_AXI_RREADY;
    lpgbt_uplink_pkg::uplink_frame_t uplink_data_i;
    logic                            uplink_strobe_i;
    logic                            uplink_ready_i;
    logic                            uplink_fec_i;
    logic                            uplink_rst_o;
    logic                            mgt_rxpolarity_o;

    int          mismatch_count = 0;
    int          failure_count  = 0;
    logic [31:0] rng_state;

    lpgbt_uplink_ctrl_top UUT (.*);

    // 10 ns clock
    always #5 S_AXI_ACLK = ~S_AXI_ACLK;

    ////////////////////////////////////////////////////////////////////////////
    // Checks and helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_data(input lpgbt_uplink_pkg::axi_data_t got,
                                input lpgbt_uplink_pkg::axi_data_t exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s, got 0x%08h expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic compare_frame(input lpgbt_uplink_pkg::uplink_frame_t got,
                                 input lpgbt_uplink_pkg::uplink_frame_t exp,
                                 input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s, got 0x%h expected 0x%h", $time, what, got, exp);
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        failure_count++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // xorshift32 step returning one new word per call
    function automatic lpgbt_uplink_pkg::axi_data_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic lpgbt_uplink_pkg::uplink_frame_t random_frame();
        logic [SNAP_WORDS*32-1:0] bits;
        for (int w = 0; w < SNAP_WORDS; w++) begin
            bits[32*w +: 32] = next_random();
        end
        return bits[`LPGBT_FRAME_WIDTH-1:0];
    endfunction

    function automatic lpgbt_uplink_pkg::axi_addr_t reg_addr(input int index);
        return lpgbt_uplink_pkg::axi_addr_t'(index * 4);
    endfunction

    // Step to the drive point 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge S_AXI_ACLK);
        #1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // AXI4-Lite master
    ////////////////////////////////////////////////////////////////////////////

    // Waits for BVALID or RVALID and holds ready low for stall cycles while checking stability
    task automatic collect_response(input bit is_read, input int stall, input string channel,
                                    output lpgbt_uplink_pkg::axi_data_t data);
        int                          waits;
        int                          held;
        bit                          done;
        logic                        valid;
        logic                        ready_now;
        logic [1:0]                  resp;
        lpgbt_uplink_pkg::axi_data_t first;
        waits = 0;
        held  = 0;
        done  = 1'b0;
        first = '0;
        if (is_read) begin
            S_AXI_RREADY = (stall == 0);
        end else begin
            S_AXI_BREADY = (stall == 0);
        end
        while (!done && waits < TIMEOUT_CYCLES) begin
            @(negedge S_AXI_ACLK);
            valid     = is_read ? S_AXI_RVALID : S_AXI_BVALID;
            resp      = is_read ? S_AXI_RRESP : S_AXI_BRESP;
            ready_now = is_read ? S_AXI_RREADY : S_AXI_BREADY;
            if (valid) begin
                if (held == 0) begin
                    compare_resp(resp, 2'b00, $sformatf("%s response code", channel));
                    if (is_read) begin
                        first = S_AXI_RDATA;
                    end
                end else if (is_read) begin
                    compare_data(S_AXI_RDATA, first, "RDATA changed while RREADY low");
                end
                held++;
                done = ready_now;
            end else if (held > 0) begin
                report_failure($sformatf("%s response valid dropped before ready", channel));
                done = 1'b1;
            end
            waits++;
            next_cycle();
            // Release back-pressure once the stall is over
            if (!done && held >= stall) begin
                if (is_read) begin
                    S_AXI_RREADY = 1'b1;
                end else begin
                    S_AXI_BREADY = 1'b1;
                end
            end
        end
        if (!done) begin
            report_failure($sformatf("timeout waiting for the %s response", channel));
        end
        S_AXI_RREADY = 1'b0;
        S_AXI_BREADY = 1'b0;
        data = first;
    endtask

    task automatic axi_write(input lpgbt_uplink_pkg::axi_addr_t addr,
                             input lpgbt_uplink_pkg::axi_data_t data,
                             input lpgbt_uplink_pkg::byte_strobe_t strb, input int stall);
        int                          waits;
        bit                          accepted;
        lpgbt_uplink_pkg::axi_data_t unused;
        S_AXI_AWADDR  = addr;
        S_AXI_WDATA   = data;
        S_AXI_WSTRB   = strb;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
        waits    = 0;
        accepted = 1'b0;
        while (!accepted && waits < TIMEOUT_CYCLES) begin
            @(negedge S_AXI_ACLK);
            accepted = S_AXI_AWREADY && S_AXI_WREADY;
            waits++;
            next_cycle();
        end
        S_AXI_AWVALID = 1'b0;
        S_AXI_WVALID  = 1'b0;
        if (!accepted) begin
            report_failure("timeout waiting for AWREADY and WREADY");
        end else begin
            collect_response(1'b0, stall, "write", unused);
        end
    endtask

    task automatic axi_read(input lpgbt_uplink_pkg::axi_addr_t addr, input int stall,
                            output lpgbt_uplink_pkg::axi_data_t data);
        int waits;
        bit accepted;
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        waits    = 0;
        accepted = 1'b0;
        data     = '0;
        while (!accepted && waits < TIMEOUT_CYCLES) begin
            @(negedge S_AXI_ACLK);
            accepted = S_AXI_ARREADY;
            waits++;
            next_cycle();
        end
        S_AXI_ARVALID = 1'b0;
        // Address moves after the handshake so RDATA must come from the held copy
        S_AXI_ARADDR  = ~addr;
        if (!accepted) begin
            report_failure("timeout waiting for ARREADY");
        end else begin
            collect_response(1'b1, stall, "read", data);
        end
    endtask

    // Drives one frame strobe and leaves ready at the given level
    task automatic send_frame(input lpgbt_uplink_pkg::uplink_frame_t data,
                              input logic ready, input logic fec);
        uplink_data_i   = data;
        uplink_ready_i  = ready;
        uplink_fec_i    = fec;
        uplink_strobe_i = 1'b1;
        next_cycle();
        uplink_strobe_i = 1'b0;
        uplink_fec_i    = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_reset_values();
        lpgbt_uplink_pkg::axi_data_t rd;
        compare_bit(uplink_rst_o, 1'b0, "uplink_rst_o after reset");
        compare_bit(mgt_rxpolarity_o, 1'b0, "mgt_rxpolarity_o after reset");
        compare_bit(S_AXI_AWREADY, 1'b0, "AWREADY after reset");
        compare_bit(S_AXI_WREADY, 1'b0, "WREADY after reset");
        compare_bit(S_AXI_ARREADY, 1'b0, "ARREADY after reset");
        compare_bit(S_AXI_BVALID, 1'b0, "BVALID after reset");
        compare_bit(S_AXI_RVALID, 1'b0, "RVALID after reset");
        // Control, status and both counters
        for (int i = `LPGBT_REG_CONTROL; i <= `LPGBT_REG_FEC_CNT; i++) begin
            axi_read(reg_addr(i), 0, rd);
            compare_data(rd, '0, $sformatf("register %0d after reset", i));
        end
    endtask

    task automatic check_control_write();
        lpgbt_uplink_pkg::axi_data_t rd;
        axi_write(reg_addr(`LPGBT_REG_CONTROL), 32'h0000_0002, 4'hF, 0);
        compare_bit(uplink_rst_o, 1'b0, "uplink_rst_o after writing 0x2");
        compare_bit(mgt_rxpolarity_o, 1'b1, "mgt_rxpolarity_o after writing 0x2");
        axi_read(reg_addr(`LPGBT_REG_CONTROL), 0, rd);
        compare_data(rd, 32'h0000_0002, "control readback after 0x2");
        // Arm bit set too but it must not read back
        axi_write(reg_addr(`LPGBT_REG_CONTROL), 32'h0000_0007, 4'hF, 0);
        compare_bit(uplink_rst_o, 1'b1, "uplink_rst_o after writing 0x7");
        compare_bit(mgt_rxpolarity_o, 1'b1, "mgt_rxpolarity_o after writing 0x7");
        axi_read(reg_addr(`LPGBT_REG_CONTROL), 0, rd);
        compare_data(rd, 32'h0000_0003, "control readback after 0x7");
        // Lane 0 disabled so only the upper lanes take the new bytes
        axi_write(reg_addr(`LPGBT_REG_CONTROL), 32'hA5A5_A500, 4'hE, 0);
        compare_bit(uplink_rst_o, 1'b1, "uplink_rst_o with lane 0 off");
        compare_bit(mgt_rxpolarity_o, 1'b1, "mgt_rxpolarity_o with lane 0 off");
        axi_read(reg_addr(`LPGBT_REG_CONTROL), 0, rd);
        compare_data(rd, 32'hA5A5_A503, "control readback with lane 0 off");
        axi_write(reg_addr(`LPGBT_REG_CONTROL), 32'h0000_0000, 4'hF, 0);
        compare_bit(uplink_rst_o, 1'b0, "uplink_rst_o after clearing control");
        compare_bit(mgt_rxpolarity_o, 1'b0, "mgt_rxpolarity_o after clearing control");
    endtask

    task automatic check_counting();
        lpgbt_uplink_pkg::axi_data_t rd;
        int                          fec_expected;
        fec_expected = 0;
        for (int i = 0; i < 6; i++) begin
            send_frame(random_frame(), 1'b1, (i % 3) == 0);
            if ((i % 3) == 0) begin
                fec_expected++;
            end
        end
        // Frames are ignored while the link is not ready
        for (int i = 0; i < 3; i++) begin
            send_frame(random_frame(), 1'b0, 1'b0);
        end
        axi_read(reg_addr(`LPGBT_REG_FRAME_CNT), 0, rd);
        compare_data(rd, 32'd6, "frame count");
        axi_read(reg_addr(`LPGBT_REG_FEC_CNT), 0, rd);
        compare_data(rd, fec_expected, "FEC count");
        // Uplink reset clears both counters
        axi_write(reg_addr(`LPGBT_REG_CONTROL), 32'h0000_0001, 4'hF, 0);
        compare_bit(uplink_rst_o, 1'b1, "uplink_rst_o during counter clear");
        axi_write(reg_addr(`LPGBT_REG_CONTROL), 32'h0000_0000, 4'hF, 0);
        axi_read(reg_addr(`LPGBT_REG_FRAME_CNT), 0, rd);
        compare_data(rd, '0, "frame count after uplink reset");
        axi_read(reg_addr(`LPGBT_REG_FEC_CNT), 0, rd);
        compare_data(rd, '0, "FEC count after uplink reset");
    endtask

    task automatic check_capture();
        lpgbt_uplink_pkg::axi_data_t     rd;
        lpgbt_uplink_pkg::uplink_frame_t first_frame;
        logic [SNAP_WORDS*32-1:0]        snap;
        uplink_ready_i = 1'b1;
        first_frame    = random_frame();
        axi_write(reg_addr(`LPGBT_REG_CONTROL), 32'h0000_0004, 4'h1, 0);
        axi_read(reg_addr(`LPGBT_REG_STATUS), 0, rd);
        compare_data(rd, (32'd1 << `LPGBT_STAT_READY_BIT) | (32'd1 << `LPGBT_STAT_ARMED_BIT),
                     "status while armed");
        send_frame(first_frame, 1'b1, 1'b0);
        // Second frame must not overwrite the snapshot
        send_frame(random_frame(), 1'b1, 1'b0);
        axi_read(reg_addr(`LPGBT_REG_STATUS), 0, rd);
        compare_data(rd, (32'd1 << `LPGBT_STAT_READY_BIT) | (32'd1 << `LPGBT_STAT_VALID_BIT),
                     "status after capture");
        for (int w = 0; w < SNAP_WORDS; w++) begin
            axi_read(reg_addr(`LPGBT_REG_SNAP_BASE + w), 0, rd);
            snap[32*w +: 32] = rd;
        end
        compare_frame(snap[`LPGBT_FRAME_WIDTH-1:0], first_frame, "captured frame");
        compare_data(snap[SNAP_WORDS*32-1 -: 32] >> LAST_WORD_BITS, '0,
                     "unused bits of the last snapshot word");
    endtask

    task automatic check_backpressure();
        lpgbt_uplink_pkg::axi_data_t rd;
        axi_write(reg_addr(`LPGBT_REG_CONTROL), 32'h0000_0002, 4'hF, 4);
        axi_read(reg_addr(`LPGBT_REG_CONTROL), 4, rd);
        compare_data(rd, 32'h0000_0002, "control readback under RREADY stall");
        // Unmapped index reads zero with OKAY
        axi_read(reg_addr(13), 3, rd);
        compare_data(rd, '0, "unmapped index 13");
        axi_write(reg_addr(`LPGBT_REG_CONTROL), 32'h0000_0000, 4'hF, 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        S_AXI_ARESETN   = 1'b0;
        S_AXI_AWADDR    = '0;
        S_AXI_AWPROT    = 3'b000;
        S_AXI_AWVALID   = 1'b0;
        S_AXI_WDATA     = '0;
        S_AXI_WSTRB     = '0;
        S_AXI_WVALID    = 1'b0;
        S_AXI_BREADY    = 1'b0;
        S_AXI_ARADDR    = '0;
        S_AXI_ARPROT    = 3'b000;
        S_AXI_ARVALID   = 1'b0;
        S_AXI_RREADY    = 1'b0;
        uplink_data_i   = '0;
        uplink_strobe_i = 1'b0;
        uplink_ready_i  = 1'b0;
        uplink_fec_i    = 1'b0;
        rng_state       = 32'd33;
        repeat (2) @(posedge S_AXI_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;
        next_cycle();
        check_reset_values();
        check_control_write();
        check_counting();
        check_capture();
        check_backpressure();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* lpgbt_uplink_ctrl_top.f */
+incdir+rtl
rtl/lpgbt_uplink_pkg.sv
rtl/lpgbt_reg_if.sv
rtl/axi4lite_slave_fsm.sv
rtl/uplink_event_counters.sv
rtl/uplink_reg_bank.sv
rtl/lpgbt_uplink_ctrl_top.sv
testbench/tb_lpgbt_uplink_ctrl.sv

/* Bender.yml */
package:
  name: lpgbt_uplink_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lpgbt_uplink_pkg.sv
      - rtl/lpgbt_reg_if.sv
      - rtl/axi4lite_slave_fsm.sv
      - rtl/uplink_event_counters.sv
      - rtl/uplink_reg_bank.sv
      - rtl/lpgbt_uplink_ctrl_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_lpgbt_uplink_ctrl.sv
